//--- source/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// cache geometry, sizes given as log2 of bytes
`define LSU_CACHE_SIZE_E 10
`define LSU_LINE_SIZE_E 5
`define LSU_ASSOC 2
`define LSU_SETS ((1 << (`LSU_CACHE_SIZE_E - `LSU_LINE_SIZE_E)) / `LSU_ASSOC)

// one memory transfer moves a whole line, word by word
`define LSU_WORDS_PER_LINE (1 << (`LSU_LINE_SIZE_E - 2))

// field widths derived from the geometry
`define LSU_SET_W ($clog2(`LSU_SETS))
`define LSU_WAY_W ($clog2(`LSU_ASSOC))
`define LSU_WORD_W (`LSU_LINE_SIZE_E - 2)
`define LSU_TAG_W (32 - `LSU_SET_W - `LSU_LINE_SIZE_E)
`define LSU_LINE_ADDR_W (32 - `LSU_LINE_SIZE_E)

`define LSU_ID_W 4

`endif

//--- source/lsu_pkg.sv
`include "lsu_consts.svh"

package lsuPkg;

    typedef struct packed {
        logic [`LSU_TAG_W-1:0] tag;
        logic [`LSU_SET_W-1:0] set;
        logic [`LSU_LINE_SIZE_E-1:0] offset;
    } addrFields;

    // same address word, raw or split into cache fields
    typedef union packed {
        logic [31:0] raw;
        addrFields f;
    } memAddr;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } accessSize;

    typedef struct packed {
        logic valid;
        memAddr addr;
        accessSize size;
        logic signExtend;
        logic [`LSU_ID_W-1:0] id;
    } loadOp;

    typedef struct packed {
        logic valid;
        memAddr addr;
        logic [31:0] data;
        logic [3:0] wmask;
        logic [`LSU_ID_W-1:0] id;
    } storeOp;

    typedef struct packed {
        logic valid;
        logic fail;
        logic [`LSU_ID_W-1:0] id;
        logic [31:0] result;
    } loadResult;

    typedef struct packed {
        logic valid;
        logic fail;
        logic [`LSU_ID_W-1:0] id;
    } storeAck;

    typedef struct packed {
        logic valid;
        memAddr addr;
    } missReport;

    typedef struct packed {
        logic valid;
        logic write;
        logic [`LSU_LINE_ADDR_W-1:0] lineAddr;
    } memReq;

    typedef struct packed {
        logic valid;
        logic [31:0] data;
    } memWord;

    // one way of the tag table as seen by the lookups
    typedef struct packed {
        logic valid;
        logic [`LSU_TAG_W-1:0] tag;
    } tagEntry;

endpackage

//--- source/cacheArrays.sv
`include "lsu_consts.svh"

module cacheArrays (
    input  logic clk,
    input  logic rst,
    input  logic [`LSU_SET_W-1:0] ldIndex,
    input  logic [`LSU_SET_W-1:0] stIndex,
    input  logic [`LSU_SET_W-1:0] evIndex,
    input  logic [`LSU_WORD_W-1:0] ldWord,
    input  logic [`LSU_WORD_W-1:0] evWord,
    input  logic [`LSU_WAY_W-1:0] evWay,
    output lsuPkg::tagEntry [`LSU_ASSOC-1:0] ldTags,
    output lsuPkg::tagEntry [`LSU_ASSOC-1:0] stTags,
    output logic [`LSU_ASSOC-1:0][31:0] ldData,
    input  logic stWe,
    input  logic [`LSU_WAY_W-1:0] stWay,
    input  logic [`LSU_SET_W-1:0] stSet,
    input  logic [`LSU_WORD_W-1:0] stWordIdx,
    input  logic [31:0] stData,
    input  logic [3:0] stMask,
    input  logic tagWe,
    input  logic [`LSU_WAY_W-1:0] tagWay,
    input  logic [`LSU_SET_W-1:0] tagSet,
    input  logic [`LSU_TAG_W-1:0] tagValue,
    input  logic tagValid,
    input  logic refWe,
    input  logic [`LSU_WAY_W-1:0] refWay,
    input  logic [`LSU_SET_W-1:0] refSet,
    input  logic [`LSU_WORD_W-1:0] refWordIdx,
    input  logic [31:0] refData,
    output logic [`LSU_TAG_W-1:0] evTag,
    output logic [31:0] evData
);

    logic [`LSU_TAG_W-1:0] tagMem [`LSU_ASSOC][`LSU_SETS];
    logic [`LSU_SETS-1:0][`LSU_ASSOC-1:0] validBits;
    logic [31:0] dataMem [`LSU_ASSOC][`LSU_SETS][`LSU_WORDS_PER_LINE];

    // lookups see every way of the indexed set at once
    always_comb begin
        for (int w = 0; w < `LSU_ASSOC; w++) begin
            ldTags[w].valid = validBits[ldIndex][w];
            ldTags[w].tag = tagMem[w][ldIndex];
            stTags[w].valid = validBits[stIndex][w];
            stTags[w].tag = tagMem[w][stIndex];
            ldData[w] = dataMem[w][ldIndex][ldWord];
        end
    end

    assign evTag = tagMem[evWay][evIndex];
    assign evData = dataMem[evWay][evIndex][evWord];

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
        end else if (tagWe) begin
            validBits[tagSet][tagWay] <= tagValid;
        end
    end

    always_ff @(posedge clk) begin
        if (tagWe) begin
            tagMem[tagWay][tagSet] <= tagValue;
        end
    end

    // stores and refill never target the same line
    always_ff @(posedge clk) begin
        if (stWe) begin
            for (int b = 0; b < 4; b++) begin
                if (stMask[b]) begin
                    dataMem[stWay][stSet][stWordIdx][8*b +: 8] <= stData[8*b +: 8];
                end
            end
        end
        if (refWe) begin
            dataMem[refWay][refSet][refWordIdx] <= refData;
        end
    end

endmodule

//--- source/loadPipe.sv
`include "lsu_consts.svh"

module loadPipe (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  lsuPkg::loadOp ld,
    output logic [`LSU_SET_W-1:0] ldIndex,
    output logic [`LSU_WORD_W-1:0] ldWord,
    input  lsuPkg::tagEntry [`LSU_ASSOC-1:0] ldTags,
    input  logic [`LSU_ASSOC-1:0][31:0] ldData,
    output lsuPkg::loadResult ldRes,
    output lsuPkg::missReport miss
);

    lsuPkg::loadOp op0;
    lsuPkg::memAddr missAddr;
    logic hit;
    logic [31:0] hitWord;
    logic [31:0] shifted;
    logic [31:0] formatted;

    // stage 0 holds the accepted load
    always_ff @(posedge clk) begin
        if (rst) begin
            op0.valid <= 1'b0;
        end else begin
            op0 <= ld;
            op0.valid <= ld.valid && !stall;
        end
    end

    assign ldIndex = op0.addr.f.set;
    assign ldWord = op0.addr.f.offset[`LSU_LINE_SIZE_E-1:2];

    always_comb begin
        hit = 1'b0;
        hitWord = '0;
        for (int w = 0; w < `LSU_ASSOC; w++) begin
            if (ldTags[w].valid && ldTags[w].tag == op0.addr.f.tag) begin
                hit = 1'b1;
                hitWord = ldData[w];
            end
        end
    end

    // move the addressed byte or half down to bit 0
    assign shifted = hitWord >> {op0.addr.f.offset[1:0], 3'b000};

    always_comb begin
        case (op0.size)
            lsuPkg::SIZE_BYTE: formatted = {{24{op0.signExtend && shifted[7]}}, shifted[7:0]};
            lsuPkg::SIZE_HALF: formatted = {{16{op0.signExtend && shifted[15]}}, shifted[15:0]};
            default: formatted = hitWord;
        endcase
    end

    // stage 1 carries the result out, a miss fails the load
    always_ff @(posedge clk) begin
        if (rst) begin
            ldRes.valid <= 1'b0;
        end else begin
            ldRes.valid <= op0.valid;
            ldRes.fail <= !hit;
            ldRes.id <= op0.id;
            ldRes.result <= formatted;
            missAddr <= op0.addr;
        end
    end

    assign miss.valid = ldRes.valid && ldRes.fail;
    assign miss.addr = missAddr;

endmodule

//--- source/storePipe.sv
`include "lsu_consts.svh"

module storePipe (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  lsuPkg::storeOp st,
    output logic [`LSU_SET_W-1:0] stIndex,
    input  lsuPkg::tagEntry [`LSU_ASSOC-1:0] stTags,
    output logic stWe,
    output logic [`LSU_WAY_W-1:0] stWay,
    output logic [`LSU_SET_W-1:0] stSet,
    output logic [`LSU_WORD_W-1:0] stWordIdx,
    output logic [31:0] stData,
    output logic [3:0] stMask,
    output logic [`LSU_WAY_W-1:0] dirtyWay,
    output logic [`LSU_SET_W-1:0] dirtySet,
    output lsuPkg::storeAck stAck,
    output lsuPkg::missReport miss
);

    lsuPkg::storeOp op0;
    lsuPkg::storeOp op1;
    logic hit;
    logic hit1;
    logic [`LSU_WAY_W-1:0] hitWay;
    logic [`LSU_WAY_W-1:0] way1;

    always_ff @(posedge clk) begin
        if (rst) begin
            op0.valid <= 1'b0;
            op1.valid <= 1'b0;
        end else begin
            op0 <= st;
            op0.valid <= st.valid && !stall;
            op1 <= op0;
            hit1 <= hit;
            way1 <= hitWay;
        end
    end

    assign stIndex = op0.addr.f.set;

    always_comb begin
        hit = 1'b0;
        hitWay = '0;
        for (int w = 0; w < `LSU_ASSOC; w++) begin
            if (stTags[w].valid && stTags[w].tag == op0.addr.f.tag) begin
                hit = 1'b1;
                hitWay = w[`LSU_WAY_W-1:0];
            end
        end
    end

    // the write only happens once the hit is known
    assign stWe = op1.valid && hit1;
    assign stWay = way1;
    assign stSet = op1.addr.f.set;
    assign stWordIdx = op1.addr.f.offset[`LSU_LINE_SIZE_E-1:2];
    assign stData = op1.data;
    assign stMask = op1.wmask;
    assign dirtyWay = way1;
    assign dirtySet = op1.addr.f.set;

    assign stAck.valid = op1.valid;
    assign stAck.fail = !hit1;
    assign stAck.id = op1.id;
    assign miss.valid = op1.valid && !hit1;
    assign miss.addr = op1.addr;

endmodule

//--- source/missHandler.sv
`include "lsu_consts.svh"

module missHandler (
    input  logic clk,
    input  logic rst,
    input  lsuPkg::missReport ldMiss,
    input  lsuPkg::missReport stMiss,
    input  logic stWe,
    input  logic [`LSU_WAY_W-1:0] dirtyWay,
    input  logic [`LSU_SET_W-1:0] dirtySet,
    output logic [`LSU_SET_W-1:0] evIndex,
    output logic [`LSU_WORD_W-1:0] evWord,
    output logic [`LSU_WAY_W-1:0] evWay,
    input  logic [`LSU_TAG_W-1:0] evTag,
    input  logic [31:0] evData,
    output logic tagWe,
    output logic [`LSU_WAY_W-1:0] tagWay,
    output logic [`LSU_SET_W-1:0] tagSet,
    output logic [`LSU_TAG_W-1:0] tagValue,
    output logic tagValid,
    output logic refWe,
    output logic [`LSU_WAY_W-1:0] refWay,
    output logic [`LSU_SET_W-1:0] refSet,
    output logic [`LSU_WORD_W-1:0] refWordIdx,
    output logic [31:0] refData,
    output logic stall,
    output lsuPkg::memReq memCmd,
    output lsuPkg::memWord memWr,
    input  lsuPkg::memWord memRd
);

    typedef enum logic [2:0] {IDLE, EV_REQ, EV_DATA, RF_REQ, RF_RECV} handlerState;

    handlerState state;
    lsuPkg::memAddr pickAddr;
    lsuPkg::memAddr missAddr;
    logic [`LSU_WAY_W-1:0] rrPtr;
    logic [`LSU_WAY_W-1:0] victimWay;
    logic [`LSU_TAG_W-1:0] victimTag;
    logic [`LSU_WORD_W-1:0] wordCnt;
    logic [`LSU_ASSOC-1:0][`LSU_SETS-1:0] dirty;
    logic capture;
    logic finish;
    logic victimDirty;

    // load report wins, reports seen during a stall are dropped
    assign capture = (state == IDLE) && (ldMiss.valid || stMiss.valid);
    assign pickAddr = ldMiss.valid ? ldMiss.addr : stMiss.addr;
    assign finish = (state == RF_RECV) && memRd.valid && (&wordCnt);
    assign stall = (state != IDLE);

    // a store that looked up the victim before its invalidation can still strobe here
    assign victimDirty = dirty[victimWay][missAddr.f.set]
        || (stWe && dirtyWay == victimWay && dirtySet == missAddr.f.set);

    // in idle the read port looks at the victim about to be chosen
    assign evIndex = (state == IDLE) ? pickAddr.f.set : missAddr.f.set;
    assign evWay = (state == IDLE) ? rrPtr : victimWay;
    assign evWord = wordCnt;

    // invalidate on capture, revalidate with the new tag on the last refill word
    always_comb begin
        tagWe = capture || finish;
        if (state == IDLE) begin
            tagWay = rrPtr;
            tagSet = pickAddr.f.set;
            tagValue = pickAddr.f.tag;
            tagValid = 1'b0;
        end else begin
            tagWay = victimWay;
            tagSet = missAddr.f.set;
            tagValue = missAddr.f.tag;
            tagValid = 1'b1;
        end
    end

    assign refWe = (state == RF_RECV) && memRd.valid;
    assign refWay = victimWay;
    assign refSet = missAddr.f.set;
    assign refWordIdx = wordCnt;
    assign refData = memRd.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            rrPtr <= '0;
            wordCnt <= '0;
            dirty <= '0;
            memCmd.valid <= 1'b0;
            memWr.valid <= 1'b0;
        end else begin
            memCmd.valid <= 1'b0;
            memWr.valid <= 1'b0;
            if (stWe) begin
                dirty[dirtyWay][dirtySet] <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (capture) begin
                        missAddr <= pickAddr;
                        victimWay <= rrPtr;
                        victimTag <= evTag;
                        rrPtr <= rrPtr + 1'b1;
                        state <= EV_REQ;
                    end
                end
                EV_REQ: begin
                    memCmd.valid <= 1'b1;
                    wordCnt <= '0;
                    if (victimDirty) begin
                        memCmd.write <= 1'b1;
                        memCmd.lineAddr <= {victimTag, missAddr.f.set};
                        state <= EV_DATA;
                    end else begin
                        // clean victim goes straight to the refill
                        memCmd.write <= 1'b0;
                        memCmd.lineAddr <= missAddr.raw[31:`LSU_LINE_SIZE_E];
                        state <= RF_RECV;
                    end
                end
                EV_DATA: begin
                    memWr.valid <= 1'b1;
                    memWr.data <= evData;
                    wordCnt <= wordCnt + 1'b1;
                    if (&wordCnt) begin
                        state <= RF_REQ;
                    end
                end
                RF_REQ: begin
                    memCmd.valid <= 1'b1;
                    memCmd.write <= 1'b0;
                    memCmd.lineAddr <= missAddr.raw[31:`LSU_LINE_SIZE_E];
                    state <= RF_RECV;
                end
                RF_RECV: begin
                    if (memRd.valid) begin
                        wordCnt <= wordCnt + 1'b1;
                    end
                    if (finish) begin
                        dirty[victimWay][missAddr.f.set] <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- source/lsuTop.sv
`include "lsu_consts.svh"

module lsuTop (
    input  logic clk,
    input  logic rst,
    input  lsuPkg::loadOp ld,
    input  lsuPkg::storeOp st,
    output lsuPkg::loadResult ldRes,
    output lsuPkg::storeAck stAck,
    output logic stall,
    output lsuPkg::memReq memCmd,
    output lsuPkg::memWord memWr,
    input  lsuPkg::memWord memRd
);

    // array lookup ports
    logic [`LSU_SET_W-1:0] ldIndex;
    logic [`LSU_SET_W-1:0] stIndex;
    logic [`LSU_SET_W-1:0] evIndex;
    logic [`LSU_WORD_W-1:0] ldWord;
    logic [`LSU_WORD_W-1:0] evWord;
    logic [`LSU_WAY_W-1:0] evWay;
    lsuPkg::tagEntry [`LSU_ASSOC-1:0] ldTags;
    lsuPkg::tagEntry [`LSU_ASSOC-1:0] stTags;
    logic [`LSU_ASSOC-1:0][31:0] ldData;
    logic [`LSU_TAG_W-1:0] evTag;
    logic [31:0] evData;

    // store write port and dirty strobe
    logic stWe;
    logic [`LSU_WAY_W-1:0] stWay;
    logic [`LSU_SET_W-1:0] stSet;
    logic [`LSU_WORD_W-1:0] stWordIdx;
    logic [31:0] stData;
    logic [3:0] stMask;
    logic [`LSU_WAY_W-1:0] dirtyWay;
    logic [`LSU_SET_W-1:0] dirtySet;

    // handler writes
    logic tagWe;
    logic [`LSU_WAY_W-1:0] tagWay;
    logic [`LSU_SET_W-1:0] tagSet;
    logic [`LSU_TAG_W-1:0] tagValue;
    logic tagValid;
    logic refWe;
    logic [`LSU_WAY_W-1:0] refWay;
    logic [`LSU_SET_W-1:0] refSet;
    logic [`LSU_WORD_W-1:0] refWordIdx;
    logic [31:0] refData;

    lsuPkg::missReport ldMiss;
    lsuPkg::missReport stMiss;

    cacheArrays cacheArrays_inst (
        .clk(clk), .rst(rst),
        .ldIndex(ldIndex), .stIndex(stIndex), .evIndex(evIndex),
        .ldWord(ldWord), .evWord(evWord), .evWay(evWay),
        .ldTags(ldTags), .stTags(stTags), .ldData(ldData),
        .stWe(stWe), .stWay(stWay), .stSet(stSet),
        .stWordIdx(stWordIdx), .stData(stData), .stMask(stMask),
        .tagWe(tagWe), .tagWay(tagWay), .tagSet(tagSet),
        .tagValue(tagValue), .tagValid(tagValid),
        .refWe(refWe), .refWay(refWay), .refSet(refSet),
        .refWordIdx(refWordIdx), .refData(refData),
        .evTag(evTag), .evData(evData)
    );

    loadPipe loadPipe_inst (
        .clk(clk), .rst(rst), .stall(stall), .ld(ld),
        .ldIndex(ldIndex), .ldWord(ldWord), .ldTags(ldTags), .ldData(ldData),
        .ldRes(ldRes), .miss(ldMiss)
    );

    storePipe storePipe_inst (
        .clk(clk), .rst(rst), .stall(stall), .st(st),
        .stIndex(stIndex), .stTags(stTags),
        .stWe(stWe), .stWay(stWay), .stSet(stSet),
        .stWordIdx(stWordIdx), .stData(stData), .stMask(stMask),
        .dirtyWay(dirtyWay), .dirtySet(dirtySet),
        .stAck(stAck), .miss(stMiss)
    );

    missHandler missHandler_inst (
        .clk(clk), .rst(rst), .ldMiss(ldMiss), .stMiss(stMiss),
        .stWe(stWe), .dirtyWay(dirtyWay), .dirtySet(dirtySet),
        .evIndex(evIndex), .evWord(evWord), .evWay(evWay),
        .evTag(evTag), .evData(evData),
        .tagWe(tagWe), .tagWay(tagWay), .tagSet(tagSet),
        .tagValue(tagValue), .tagValid(tagValid),
        .refWe(refWe), .refWay(refWay), .refSet(refSet),
        .refWordIdx(refWordIdx), .refData(refData),
        .stall(stall), .memCmd(memCmd), .memWr(memWr), .memRd(memRd)
    );

endmodule

//--- tb/lsu_asserts.sv
module lsuAsserts (
    input logic clk,
    input logic rst,
    input lsuPkg::loadOp ld,
    input lsuPkg::storeOp st,
    input lsuPkg::loadResult ldRes,
    input lsuPkg::storeAck stAck,
    input logic stall,
    input lsuPkg::memReq memCmd,
    input lsuPkg::memWord memWr
);
    timeunit 1ns;
    timeprecision 100ps;

    logic ldTaken;
    logic stTaken;
    logic readReq;
    logic readBusy;

    assign ldTaken = ld.valid && !stall;
    assign stTaken = st.valid && !stall;
    assign readReq = memCmd.valid && !memCmd.write;

    // a read transfer lasts until the handler drops stall
    always_ff @(posedge clk) begin
        if (rst) begin
            readBusy <= 1'b0;
        end else if (readReq) begin
            readBusy <= 1'b1;
        end else if (!stall) begin
            readBusy <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) $past(ldTaken, 2) |-> ldRes.valid)
        else $error("accepted load got no result two edges later");

    assert property (@(posedge clk) disable iff (rst) ldRes.valid |-> $past(ldTaken, 2))
        else $error("load result without an accepted load");

    assert property (@(posedge clk) disable iff (rst) $past(stTaken, 2) |-> stAck.valid)
        else $error("accepted store got no acknowledge two edges later");

    assert property (@(posedge clk) disable iff (rst) stAck.valid |-> $past(stTaken, 2))
        else $error("store acknowledge without an accepted store");

    assert property (@(posedge clk) disable iff (rst) (readBusy || readReq) |-> !memWr.valid)
        else $error("memWr.valid high during a read transfer");

endmodule

bind lsuTop lsuAsserts lsuAsserts_inst (
    .clk(clk), .rst(rst), .ld(ld), .st(st), .ldRes(ldRes), .stAck(stAck),
    .stall(stall), .memCmd(memCmd), .memWr(memWr)
);

//--- tb/lsuTb.sv
`include "lsu_consts.svh"

module lsuTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_OPS = 400;
    localparam int DIRECTED_OPS = 18;
    localparam int TOTAL_OPS = NUM_OPS + DIRECTED_OPS;
    localparam int NUM_LINES = 64;
    localparam int WPL = `LSU_WORDS_PER_LINE;
    localparam int MEM_WORDS = NUM_LINES * WPL;
    localparam logic [31:0] BASE = 32'h0004_0000;
    localparam logic [31:0] SEED = 32'h0a51_ef95;

    logic clk;
    logic rst;
    lsuPkg::loadOp ld;
    lsuPkg::storeOp st;
    lsuPkg::loadResult ldRes;
    lsuPkg::storeAck stAck;
    logic stall;
    lsuPkg::memReq memCmd;
    lsuPkg::memWord memWr;
    lsuPkg::memWord memRd;

    // architectural state and what the memory side holds
    logic [31:0] refMem [MEM_WORDS];
    logic [31:0] backMem [MEM_WORDS];
    logic refilled [NUM_LINES];
    logic dirtyLine [NUM_LINES];
    // which tested line each way of each set holds, -1 when empty
    int wayLine [`LSU_SETS][`LSU_ASSOC];
    int errors = 0;
    int loads = 0;
    int stores = 0;
    int refills = 0;
    int writebacks = 0;

    lsuTop lsuTop_inst (
        .clk(clk), .rst(rst), .ld(ld), .st(st), .ldRes(ldRes), .stAck(stAck),
        .stall(stall), .memCmd(memCmd), .memWr(memWr), .memRd(memRd)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        errors++;
        $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic reportFailure(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    function automatic logic [31:0] fillWord(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[7:0], a[31:8]};
    endfunction

    function automatic int wordIndex(input logic [31:0] addr);
        return int'((addr - BASE) >> 2);
    endfunction

    function automatic int lineOf(input logic [31:0] addr);
        return int'((addr - BASE) >> 5);
    endfunction

    function automatic logic [31:0] expectedLoad(input logic [31:0] addr,
                                                 input lsuPkg::accessSize size,
                                                 input logic sx);
        logic [31:0] w;
        logic [31:0] shiftedWord;
        w = refMem[wordIndex(addr)];
        shiftedWord = w >> (8 * addr[1:0]);
        case (size)
            lsuPkg::SIZE_BYTE: return {{24{sx & shiftedWord[7]}}, shiftedWord[7:0]};
            lsuPkg::SIZE_HALF: return {{16{sx & shiftedWord[15]}}, shiftedWord[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic applyStore(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] mask);
        int idx;
        idx = wordIndex(addr);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                refMem[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    // aligned address somewhere inside the given line
    function automatic logic [31:0] randomAddr(input int line, input lsuPkg::accessSize size);
        logic [31:0] a;
        logic [31:0] r;
        r = $urandom();
        a = BASE + (line << 5) + {27'd0, r[4:0]};
        if (size == lsuPkg::SIZE_WORD) begin
            a[1:0] = 2'b00;
        end else if (size == lsuPkg::SIZE_HALF) begin
            a[0] = 1'b0;
        end
        return a;
    endfunction

    function automatic lsuPkg::loadOp makeLoad(input int line);
        lsuPkg::loadOp op;
        logic [31:0] r;
        r = $urandom_range(2);
        if (r == 0) begin
            op.size = lsuPkg::SIZE_BYTE;
        end else if (r == 1) begin
            op.size = lsuPkg::SIZE_HALF;
        end else begin
            op.size = lsuPkg::SIZE_WORD;
        end
        r = $urandom();
        op.valid = 1'b1;
        op.signExtend = r[0];
        op.id = r[`LSU_ID_W:1];
        op.addr.raw = randomAddr(line, op.size);
        return op;
    endfunction

    function automatic lsuPkg::storeOp makeStore(input int line);
        lsuPkg::storeOp op;
        logic [31:0] r;
        r = $urandom();
        op.valid = 1'b1;
        op.wmask = r[3:0];
        op.id = r[`LSU_ID_W+3:4];
        op.data = $urandom();
        op.addr.raw = randomAddr(line, lsuPkg::SIZE_WORD);
        return op;
    endfunction

    // drive from a falling edge, retry whatever failed until both succeed
    task automatic issueOps(input logic wantLd, input lsuPkg::loadOp lop,
                            input logic wantSt, input lsuPkg::storeOp sop);
        logic ldPending;
        logic stPending;
        logic [31:0] expected;
        ldPending = wantLd;
        stPending = wantSt;
        while (ldPending || stPending) begin
            ld = lop;
            ld.valid = ldPending;
            st = sop;
            st.valid = stPending;
            while (stall) begin
                @(negedge clk);
                if (ldRes.valid || stAck.valid) begin
                    reportFailure("acknowledge while the inputs were held by stall");
                end
            end
            @(negedge clk);
            ld.valid = 1'b0;
            st.valid = 1'b0;
            if (ldRes.valid || stAck.valid) begin
                reportFailure("acknowledge came one edge after acceptance");
            end
            @(negedge clk);
            if (ldRes.valid !== ldPending) begin
                reportMismatch("ldRes.valid", 32'(ldRes.valid), 32'(ldPending));
            end else if (ldPending) begin
                if (ldRes.id !== lop.id) begin
                    reportMismatch("ldRes.id", 32'(ldRes.id), 32'(lop.id));
                end
                if (!ldRes.fail) begin
                    ldPending = 1'b0;
                    loads++;
                    if (!refilled[lineOf(lop.addr.raw)]) begin
                        reportFailure("load hit a line that was never refilled");
                    end
                    expected = expectedLoad(lop.addr.raw, lop.size, lop.signExtend);
                    if (ldRes.result !== expected) begin
                        reportMismatch("ldRes.result", ldRes.result, expected);
                    end
                end
            end
            if (stAck.valid !== stPending) begin
                reportMismatch("stAck.valid", 32'(stAck.valid), 32'(stPending));
            end else if (stPending) begin
                if (stAck.id !== sop.id) begin
                    reportMismatch("stAck.id", 32'(stAck.id), 32'(sop.id));
                end
                if (!stAck.fail) begin
                    stPending = 1'b0;
                    stores++;
                    if (!refilled[lineOf(sop.addr.raw)]) begin
                        reportFailure("store hit a line that was never refilled");
                    end
                    applyStore(sop.addr.raw, sop.data, sop.wmask);
                    dirtyLine[lineOf(sop.addr.raw)] = 1'b1;
                end
            end
        end
    endtask

    // answers line transfers, refill words come with random gaps
    initial begin : memoryModel
        logic [26:0] lineOff;
        int wbLine;
        int rrModel;
        int victim;
        int line;
        int gap;
        memRd = '0;
        wbLine = -1;
        rrModel = 0;
        for (int s = 0; s < `LSU_SETS; s++) begin
            for (int w = 0; w < `LSU_ASSOC; w++) begin
                wayLine[s][w] = -1;
            end
        end
        while (rst !== 1'b0) begin
            @(negedge clk);
        end
        forever begin
            @(negedge clk);
            if (memWr.valid) begin
                reportFailure("memWr.valid outside a writeback transfer");
            end
            if (memCmd.valid) begin
                lineOff = memCmd.lineAddr - BASE[31:5];
                line = int'(lineOff);
                if (lineOff >= 27'(NUM_LINES)) begin
                    reportFailure("memory request outside the tested address range");
                end else if (memCmd.write) begin
                    writebacks++;
                    if (wbLine >= 0) begin
                        reportFailure("second writeback without a refill in between");
                    end
                    if (!dirtyLine[line]) begin
                        reportFailure("writeback of a line that no store had written");
                    end
                    dirtyLine[line] = 1'b0;
                    wbLine = line;
                    for (int w = 0; w < WPL; w++) begin
                        @(negedge clk);
                        if (!stall) begin
                            reportFailure("stall low during a writeback");
                        end
                        if (!memWr.valid) begin
                            reportFailure("writeback word missing");
                        end else begin
                            if (memWr.data !== refMem[line * WPL + w]) begin
                                reportMismatch("memWr.data", memWr.data, refMem[line * WPL + w]);
                            end
                            backMem[line * WPL + w] = memWr.data;
                        end
                    end
                end else begin
                    refills++;
                    if (dirtyLine[line]) begin
                        reportFailure("dirty line was replaced without a writeback");
                    end
                    // victim way follows one round-robin pointer for the whole cache
                    victim = wayLine[line % `LSU_SETS][rrModel];
                    if (wbLine >= 0) begin
                        if (victim != wbLine) begin
                            reportFailure("writeback was not of the round-robin victim");
                        end
                    end else if (victim >= 0 && dirtyLine[victim]) begin
                        reportFailure("dirty victim was evicted without a writeback");
                    end
                    wayLine[line % `LSU_SETS][rrModel] = line;
                    rrModel = (rrModel + 1) % `LSU_ASSOC;
                    wbLine = -1;
                    refilled[line] = 1'b1;
                    for (int w = 0; w < WPL; w++) begin
                        gap = $urandom_range(2) + ((w == 0) ? 1 : 0);
                        repeat (gap) @(negedge clk);
                        if (!stall) begin
                            reportFailure("stall dropped before the last refill word");
                        end
                        memRd.valid = 1'b1;
                        memRd.data = backMem[line * WPL + w];
                        @(negedge clk);
                        memRd.valid = 1'b0;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(TOTAL_OPS * 60 * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TOTAL_OPS * 60);
        $display("Checks failed");
        $finish;
    end

    initial begin : stimulus
        lsuPkg::loadOp lop;
        lsuPkg::storeOp sop;
        int kind;
        void'($urandom(SEED));
        rst = 1'b1;
        ld = '0;
        st = '0;
        lop = '0;
        sop = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            refMem[i] = fillWord(BASE + 32'(i * 4));
            backMem[i] = refMem[i];
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            refilled[i] = 1'b0;
            dirtyLine[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        if (stall || ldRes.valid || stAck.valid || memCmd.valid || memWr.valid) begin
            reportFailure("outputs not idle after reset");
        end
        rst = 1'b0;

        // three lines of set 5 force round-robin evictions
        for (int rep = 0; rep < 3; rep++) begin
            for (int k = 0; k < 3; k++) begin
                sop = makeStore(5 + 16 * k);
                issueOps(1'b0, lop, 1'b1, sop);
                lop = makeLoad(5 + 16 * k);
                lop.addr.raw[4:2] = sop.addr.raw[4:2];
                issueOps(1'b1, lop, 1'b0, sop);
            end
        end

        for (int i = 0; i < NUM_OPS; i++) begin
            kind = $urandom_range(2);
            lop = makeLoad($urandom_range(NUM_LINES - 1));
            sop = makeStore($urandom_range(NUM_LINES - 1));
            // a paired load must not read the word the store writes
            if (lop.addr.raw[31:2] == sop.addr.raw[31:2]) begin
                lop.addr.raw[4] = ~lop.addr.raw[4];
            end
            issueOps(kind != 1, lop, kind != 0, sop);
        end

        if (writebacks == 0) begin
            reportFailure("no dirty eviction was exercised");
        end
        $display("Summary: %0d errors, %0d loads, %0d stores, %0d refills, %0d writebacks",
                 errors, loads, stores, refills, writebacks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+source
source/lsu_pkg.sv
source/cacheArrays.sv
source/loadPipe.sv
source/storePipe.sv
source/missHandler.sv
source/lsuTop.sv
tb/lsu_asserts.sv
tb/lsuTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert
TOP = lsuTb
FILELIST = list.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_MSG = All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o simv
	./$(BUILD_DIR)/simv | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
